// File: Bender.yml
package:
  name: icache

sources:
  - rtl/icache_pkg.sv
  - rtl/icache_array_if.sv
  - rtl/icache_data_ram.sv
  - rtl/icache_tag_ram.sv
  - rtl/icache_beat_counter.sv
  - rtl/icache_line_fill.sv
  - rtl/icache_ctrl.sv
  - rtl/icache_top.sv
  - target: simulation
    files:
      - tb/icache_props.sv
      - tb/icache_tb.sv

// File: icache_top.f
rtl/icache_pkg.sv
rtl/icache_array_if.sv
rtl/icache_data_ram.sv
rtl/icache_tag_ram.sv
rtl/icache_beat_counter.sv
rtl/icache_line_fill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/icache_props.sv
tb/icache_tb.sv

// File: rtl/icache_array_if.sv
/*
 * icache array interface
 * joins the controller and the line fill to the data, tag and valid arrays
 */
`default_nettype none
`timescale 1ns/10ps

interface icache_array_if;
    import icache_pkg::*;

    // set select, shared by reads and writes
    logic [index_w-1:0] index;

    // write side, one cycle writes line, tag and valid together
    logic               wr_en;
    logic [tag_w-1:0]   wr_tag;
    logic [line_w-1:0]  wr_line;

    // clears every valid bit
    logic               inv_all;

    // combinational read side
    logic [line_w-1:0]  rd_line;
    logic [tag_w-1:0]   rd_tag;
    logic               rd_valid;

    // controller owns address, write strobe, tag and invalidate
    modport ctrl (output index, wr_en, wr_tag, inv_all,
                  input  rd_line, rd_tag, rd_valid);

    // line fill only supplies the assembled line
    modport fill (output wr_line);

    // arrays
    modport array (input  index, wr_en, wr_tag, wr_line, inv_all,
                   output rd_line, rd_tag, rd_valid);

endinterface

`default_nettype wire

// File: rtl/icache_beat_counter.sv
/*
 * icache refill beat counter
 * counts memory beats during a refill and flags the last one
 */
`default_nettype none
`timescale 1ns/10ps

module icache_beat_counter (
    input wire                            clk,
    input wire                            rst,
    input wire                            refill_start,
    input wire                            refilling,
    input wire                            mem_rvalid,
    output logic [icache_pkg::beat_w-1:0] beat,
    output logic                          last_beat
);
    import icache_pkg::*;

    // zeroed at the start of each refill
    // beats outside a refill are dropped
    always_ff @(posedge clk) begin
        if (rst || refill_start) begin
            beat <= '0;
        end else if (refilling && mem_rvalid) begin
            beat <= beat + 1'b1;
        end
    end

    // level, high for the whole time the fourth beat is awaited
    assign last_beat = (beat == beat_w'(beats_per_line - 1));

endmodule

`default_nettype wire

// File: rtl/icache_ctrl.sv
/*
 * icache controller
 * lookup and refill FSM: captures the fetch address, compares the tag,
 * requests and writes a line on a miss, returns the selected word
 */
`default_nettype none
`timescale 1ns/10ps

module icache_ctrl (
    input wire                            clk,
    input wire                            rst,
    input wire                            fetch_req,
    input wire [icache_pkg::word_w-1:0]   fetch_addr,
    input wire                            inv_all,
    output logic                          fetch_busy,
    output logic                          fetch_valid,
    output logic [icache_pkg::word_w-1:0] fetch_data,
    output logic                          mem_req,
    output logic [icache_pkg::word_w-1:0] mem_addr,
    output logic                          refill_start,
    output logic                          refilling,
    input wire                            last_beat,
    input wire                            mem_rvalid,
    icache_array_if.ctrl                  arr
);
    import icache_pkg::*;

    logic [2:0]        state;
    logic [2:0]        state_d;
    fetch_addr_t       addr_q;
    fetch_addr_t       line_addr;
    logic [word_w-1:0] data_q;
    logic              accept;
    logic              hit;

    // new fetch only from idle
    assign accept = (state == st_idle) && fetch_req;

    // tag compare on the captured address
    assign hit = arr.rd_valid && (arr.rd_tag == addr_q.f.tag);

    always_comb begin
        state_d = state;
        case (state)
            st_idle:    if (accept) state_d = st_lookup;
            st_lookup:  state_d = hit ? st_respond : st_request;
            st_request: state_d = st_fill;
            // leave after the fourth beat lands
            st_fill:    if (mem_rvalid && last_beat) state_d = st_write;
            // lookup again, now a hit
            st_write:   state_d = st_lookup;
            st_respond: state_d = st_idle;
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_d;
        end
    end

    // address and response word
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q.whole <= fetch_addr;
        end
        if (state == st_lookup && hit) begin
            data_q <= arr.rd_line[addr_q.f.word*word_w +: word_w];
        end
    end

    // line-aligned refill address
    always_comb begin
        line_addr            = addr_q;
        line_addr.f.word     = '0;
        line_addr.f.byte_off = '0;
    end

    // array side
    assign arr.index   = addr_q.f.index;
    assign arr.wr_tag  = addr_q.f.tag;
    assign arr.wr_en   = (state == st_write);
    // invalidate only between fetches
    assign arr.inv_all = inv_all && (state == st_idle);

    // fetch side, busy and valid drop on the same edge
    assign fetch_busy  = (state != st_idle);
    assign fetch_valid = (state == st_respond);
    assign fetch_data  = data_q;

    // memory side
    assign mem_req      = (state == st_request);
    assign mem_addr     = line_addr.whole;
    assign refill_start = (state == st_request);
    assign refilling    = (state == st_fill);

endmodule

`default_nettype wire

// File: rtl/icache_data_ram.sv
/*
 * icache data array
 * 32 lines of 128 bits, combinational read and clocked write
 */
`default_nettype none
`timescale 1ns/10ps

module icache_data_ram (
    input wire            clk,
    icache_array_if.array arr
);
    import icache_pkg::*;

    // line storage, one entry per set
    logic [line_w-1:0] lines [num_sets];

    // write the refilled line at the captured index
    always_ff @(posedge clk) begin
        if (arr.wr_en) begin
            lines[arr.index] <= arr.wr_line;
        end
    end

    // read follows the index with no clock
    assign arr.rd_line = lines[arr.index];

endmodule

`default_nettype wire

// File: rtl/icache_line_fill.sv
/*
 * icache line fill buffer
 * collects the four 32-bit refill beats into one 128-bit line,
 * beat 0 in the lowest word
 */
`default_nettype none
`timescale 1ns/10ps

module icache_line_fill (
    input wire                            clk,
    input wire                            refilling,
    input wire                            mem_rvalid,
    input wire [icache_pkg::word_w-1:0]   mem_rdata,
    input wire [icache_pkg::beat_w-1:0]   beat,
    icache_array_if.fill                  fill
);
    import icache_pkg::*;

    // one register per word lane
    logic [word_w-1:0] lane [beats_per_line];

    // beat accepted only inside a refill
    logic              take;

    assign take = refilling && mem_rvalid;

    // steer the beat into the lane its number selects
    always_ff @(posedge clk) begin
        if (take) begin
            lane[beat] <= mem_rdata;
        end
    end

    // lanes laid out low to high across the line
    for (genvar i = 0; i < beats_per_line; i++) begin : g_lane
        assign fill.wr_line[i*word_w +: word_w] = lane[i];
    end

endmodule

`default_nettype wire

// File: rtl/icache_pkg.sv
/*
 * icache shared definitions
 * address geometry of the direct-mapped instruction cache, the
 * controller state codes and the fetch address union
 */
`default_nettype none

package icache_pkg;

    // cache geometry, 32 sets of 16-byte lines
    localparam int num_sets       = 32;
    localparam int index_w        = 5;
    localparam int tag_w          = 23;
    localparam int offset_w       = 4;

    // line and beat widths
    localparam int line_w         = 128;
    localparam int word_w         = 32;
    localparam int beats_per_line = 4;
    localparam int beat_w         = 2;

    // controller state codes
    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_lookup  = 3'd1;
    localparam logic [2:0] st_request = 3'd2;
    localparam logic [2:0] st_fill    = 3'd3;
    localparam logic [2:0] st_write   = 3'd4;
    localparam logic [2:0] st_respond = 3'd5;

    // one byte address, seen either as a plain word for the memory port
    // or as its tag / index / word / byte fields for the lookup
    typedef union packed {
        logic [word_w-1:0] whole;
        struct packed {
            logic [tag_w-1:0]             tag;
            logic [index_w-1:0]           index;
            logic [beat_w-1:0]            word;
            logic [offset_w-beat_w-1:0]   byte_off;
        } f;
    } fetch_addr_t;

endpackage

`default_nettype wire

// File: rtl/icache_tag_ram.sv
/*
 * icache tag and valid arrays
 * 32 tags of 23 bits plus one valid bit per set; reset and invalidate
 * clear every valid bit, a refill write sets the bit of its set
 */
`default_nettype none
`timescale 1ns/10ps

module icache_tag_ram (
    input wire            clk,
    input wire            rst,
    icache_array_if.array arr
);
    import icache_pkg::*;

    // tag storage
    logic [tag_w-1:0]    tags [num_sets];

    // one valid bit per set
    logic [num_sets-1:0] valid;

    // tag written with the line
    always_ff @(posedge clk) begin
        if (arr.wr_en) begin
            tags[arr.index] <= arr.wr_tag;
        end
    end

    // clear beats a write in the same cycle
    always_ff @(posedge clk) begin
        if (rst || arr.inv_all) begin
            valid <= '0;
        end else if (arr.wr_en) begin
            valid[arr.index] <= 1'b1;
        end
    end

    // combinational lookup outputs
    assign arr.rd_tag   = tags[arr.index];
    assign arr.rd_valid = valid[arr.index];

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
/*
 * icache top level
 * direct-mapped instruction cache, 32 sets of 16-byte lines, refilled
 * from an outside memory in four 32-bit beats
 */
`default_nettype none
`timescale 1ns/10ps

module icache_top (
    input wire                           clk,
    input wire                           rst,
    // fetch port
    input wire                           fetch_req,
    input wire [icache_pkg::word_w-1:0]  fetch_addr,
    output wire                          fetch_busy,
    output wire                          fetch_valid,
    output wire [icache_pkg::word_w-1:0] fetch_data,
    // invalidate strobe
    input wire                           inv_all,
    // memory port
    output wire                          mem_req,
    output wire [icache_pkg::word_w-1:0] mem_addr,
    input wire                           mem_rvalid,
    input wire [icache_pkg::word_w-1:0]  mem_rdata
);
    import icache_pkg::*;

    // refill sequencing
    logic [beat_w-1:0] beat;
    logic              last_beat;
    logic              refill_start;
    logic              refilling;

    // controller and line fill to the arrays
    icache_array_if arr_if ();

    icache_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .inv_all      (inv_all),
        .fetch_busy   (fetch_busy),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .refill_start (refill_start),
        .refilling    (refilling),
        .last_beat    (last_beat),
        .mem_rvalid   (mem_rvalid),
        .arr          (arr_if.ctrl)
    );

    icache_beat_counter beat_cnt_i (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .refilling    (refilling),
        .mem_rvalid   (mem_rvalid),
        .beat         (beat),
        .last_beat    (last_beat)
    );

    icache_line_fill line_fill_i (
        .clk        (clk),
        .refilling  (refilling),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .beat       (beat),
        .fill       (arr_if.fill)
    );

    // line storage
    icache_data_ram data_ram_i (
        .clk (clk),
        .arr (arr_if.array)
    );

    // tags and valid bits
    icache_tag_ram tag_ram_i (
        .clk (clk),
        .rst (rst),
        .arr (arr_if.array)
    );

endmodule

`default_nettype wire

// File: tb/icache_props.sv
/*
 * icache fetch and memory timing properties
 * bound to the cache top level; checks hit timing, the refill request
 * and the returned word
 */
`default_nettype none
`timescale 1ns/10ps

module icache_props #(
    parameter logic [31:0] mem_key = 32'h0
) (
    input wire        clk,
    input wire        rst,
    input wire        fetch_req,
    input wire [31:0] fetch_addr,
    input wire        fetch_busy,
    input wire        fetch_valid,
    input wire [31:0] fetch_data,
    input wire        mem_req,
    input wire [31:0] mem_addr
);

    int          fail_cnt = 0;
    logic        accept;
    logic [31:0] cap_addr;

    assign accept = fetch_req && !fetch_busy;

    // address of the fetch in flight
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_addr <= fetch_addr;
        end
    end

    // hit answers or refill starts two edges after accept
    hit_timing: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##2 (fetch_valid != mem_req))
    else begin
        $error("no hit response or refill request after accept");
        fail_cnt++;
    end

    req_single: assert property (@(posedge clk) disable iff (rst)
        mem_req |=> !mem_req)
    else begin
        $error("mem_req held longer than one cycle");
        fail_cnt++;
    end

    req_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> (mem_addr[3:0] == 4'h0))
    else begin
        $error("mem_addr not line aligned");
        fail_cnt++;
    end

    valid_busy: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> fetch_busy)
    else begin
        $error("fetch_valid outside a busy period");
        fail_cnt++;
    end

    // word rule of the refill memory
    data_rule: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> (fetch_data == ({cap_addr[31:2], 2'b00} ^ mem_key)))
    else begin
        $error("fetch_data does not match the memory word");
        fail_cnt++;
    end

endmodule

`default_nettype wire

// File: tb/icache_tb.sv
/*
 * icache testbench
 * runs cold misses, hits, evictions, invalidate, a fetch while busy and
 * stray memory beats against the cache, with a refill memory model
 */
`default_nettype none
`timescale 1ns/10ps

module icache_tb;

    // refill memory holds each word's byte address xor this key
    localparam logic [31:0] mem_key      = 32'hC0DE_5A17;
    localparam int          clk_period   = 20;
    localparam int          reset_cycles = 10;
    localparam int          num_fetches  = 16;
    localparam int          max_gap      = 3;
    localparam int          limit_cycles = reset_cycles + num_fetches * (4 * max_gap + 10);

    // test lines, a and c share index 5 with different tags
    localparam logic [31:0] addr_a = 32'h0004_2A50;
    localparam logic [31:0] addr_c = 32'h0014_2A50;
    localparam logic [31:0] addr_d = 32'h00FF_F3C8;
    localparam logic [31:0] addr_e = 32'h0000_0000;

    logic        clk = 1'b0;
    logic        rst;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    wire         fetch_busy;
    wire         fetch_valid;
    wire  [31:0] fetch_data;
    logic        inv_all;
    wire         mem_req;
    wire  [31:0] mem_addr;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;

    int          err_cnt = 0;
    int          req_cnt = 0;
    logic [7:0]  lfsr    = 8'd76;

    always #(clk_period / 2) clk = ~clk;

    icache_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_busy  (fetch_busy),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .inv_all     (inv_all),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    // expected word for any byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ mem_key;
    endfunction

    // fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // two fresh bits give a gap of 0 to 3 cycles
    task automatic draw_gap(output int gap);
        gap = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            gap  = gap * 2 + int'(lfsr[0]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // memory model, four beats from the cycle after mem_req
    task automatic serve_refill(input logic [31:0] base);
        int gap;
        for (int b = 0; b < 4; b++) begin
            draw_gap(gap);
            repeat (gap) begin
                @(negedge clk);
                mem_rvalid = 1'b0;
            end
            @(negedge clk);
            mem_rvalid = 1'b1;
            mem_rdata  = mem_word(base + 32'(4 * b));
        end
        @(negedge clk);
        mem_rvalid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst && mem_req) begin
            serve_refill(mem_addr);
        end
    end

    // pulses seen by the memory
    always @(posedge clk) begin
        if (mem_req) begin
            req_cnt++;
        end
    end

    // one fetch; poke sends a second request three cycles in, while busy
    task automatic run_fetch(input logic [31:0] addr, input bit is_hit, input bit poke);
        int edges;
        int reqs_at_start;
        edges         = 0;
        reqs_at_start = req_cnt;
        assert (!fetch_busy) else begin
            $display("fetch to %h started while the cache was still busy", addr);
            err_cnt++;
        end
        fetch_req  = 1'b1;
        fetch_addr = addr;
        do begin
            @(negedge clk);
            edges++;
            fetch_req  = poke && (edges == 3);
            fetch_addr = (poke && edges == 3) ? ~addr : addr;
        end while (!fetch_valid);
        check_value("fetch_data", fetch_data, mem_word(addr));
        check_value("mem_req pulses", req_cnt - reqs_at_start, is_hit ? 0 : 1);
        // hit answers on the second edge after accept
        if (is_hit) begin
            check_value("hit latency", edges, 2);
        end
        @(negedge clk);
        assert (!fetch_busy && !fetch_valid) else begin
            $display("cache did not return to idle after the response to %h", addr);
            err_cnt++;
        end
    endtask

    // beats with no refill open, dropped by the cache
    task automatic stray_beats(input int cycles);
        repeat (cycles) begin
            mem_rvalid = 1'b1;
            mem_rdata  = 32'hDEAD_BEEF;
            @(negedge clk);
        end
        mem_rvalid = 1'b0;
    endtask

    initial begin
        int prop_errs;
        rst        = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        inv_all    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!fetch_busy && !fetch_valid && !mem_req) else begin
            $display("fetch or memory outputs active right after reset");
            err_cnt++;
        end
        // cold miss, then every offset of the line hits
        run_fetch(addr_a, 1'b0, 1'b0);
        run_fetch(addr_a + 32'h4, 1'b1, 1'b0);
        run_fetch(addr_a + 32'hB, 1'b1, 1'b0);
        run_fetch(addr_a + 32'hC, 1'b1, 1'b0);
        run_fetch(addr_a, 1'b1, 1'b0);
        // misses at word 0..3 on four fresh lines
        for (int k = 0; k < 4; k++) begin
            run_fetch(32'h0000_1100 + 32'(k * 21), 1'b0, 1'b0);
        end
        // same index, other tag evicts a; a then misses again
        run_fetch(addr_c, 1'b0, 1'b0);
        run_fetch(addr_a, 1'b0, 1'b0);
        // invalidate, a cached line misses
        inv_all = 1'b1;
        @(negedge clk);
        inv_all = 1'b0;
        run_fetch(addr_a, 1'b0, 1'b0);
        run_fetch(addr_a + 32'h8, 1'b1, 1'b0);
        // request while busy, then stray beats while idle
        run_fetch(addr_d, 1'b0, 1'b1);
        stray_beats(3);
        run_fetch(addr_d + 32'h4, 1'b1, 1'b0);
        run_fetch(addr_e, 1'b0, 1'b0);
        @(negedge clk);
        prop_errs = dut_i.props_i.fail_cnt;
        $display("errors: %0d testbench, %0d property", err_cnt, prop_errs);
        if (err_cnt + prop_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog, worst refill per fetch plus reset
    initial begin
        #(limit_cycles * clk_period);
        $display("timeout after %0d cycles, a fetch never completed", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// key matches mem_key of the memory model
bind icache_top icache_props #(.mem_key(32'hC0DE_5A17)) props_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_busy  (fetch_busy),
    .fetch_valid (fetch_valid),
    .fetch_data  (fetch_data),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr)
);

`default_nettype wire
